//--- sim/rvStimulus.txt
# P byteAddr word : program word for the loader, E rd value : expected register write
# H illegal : ends a program, runs it and gives the expected illegal flag; all fields hex
# program 1: ALU and forwarding, store and load, loops and jumps, ebreak
P 00 00500093 # addi x1, x0, 5
P 04 00300113 # addi x2, x0, 3
P 08 002081b3 # add  x3, x1, x2
P 0c 40118233 # sub  x4, x3, x1
P 10 003272b3 # and  x5, x4, x3
P 14 00326333 # or   x6, x4, x3
P 18 001343b3 # xor  x7, x6, x1
P 1c 00322433 # slt  x8, x4, x3
P 20 ffe00493 # addi x9, x0, -2
P 24 0014a533 # slt  x10, x9, x1
P 28 10702023 # sw   x7, 256(x0)
P 2c 10002583 # lw   x11, 256(x0)
P 30 00158633 # add  x12, x11, x1
P 34 00200693 # addi x13, x0, 2
P 38 fff68693 # addi x13, x13, -1
P 3c fe069ee3 # bne  x13, x0, -4
P 40 0080076f # jal  x14, +8
P 44 06300793 # addi x15, x0, 99 (skipped)
P 48 00700813 # addi x16, x0, 7
P 4c 00100073 # ebreak
E 01 00000005
E 02 00000003
E 03 00000008
E 04 00000003
E 05 00000000
E 06 0000000b
E 07 0000000e
E 08 00000001
E 09 fffffffe
E 0a 00000001
E 0b 0000000e
E 0c 00000013
E 0d 00000002
E 0d 00000001
E 0d 00000000
E 0e 00000044
E 10 00000007
H 0
# program 2: ends in an undefined opcode
P 00 00500093 # addi x1, x0, 5
P 04 00108113 # addi x2, x1, 1
P 08 ffffffff # undefined opcode
P 0c 00100193 # addi x3, x0, 1 (never reached)
E 01 00000005
E 02 00000006
H 1

//--- flist.f
logic/rvPkg.sv
logic/memBus.sv
logic/intAlu.sv
logic/regFile.sv
logic/instDecoder.sv
logic/fetchUnit.sv
logic/memArbiter.sv
logic/rvCore.sv
sim/tbRvCore.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tbRvCore
FLIST = flist.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "TEST FAIL" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/tbRvCore.sv
/*
  Testbench for the three-stage core. Programs, expected register writes
  and final flags come from sim/rvStimulus.txt, run from the project root.
  Each "H" line closes one program, which then runs after a fresh reset.
  Retire events are sampled on the falling edge.
*/
`timescale 1ns/1ns

module tbRvCore;

	logic clk;
	logic rstN;
	logic run;
	logic loadEn;
	logic [31:0] loadAddr;
	logic [31:0] loadData;
	logic retireValid;
	logic [4:0] retireRd;
	logic [31:0] retireData;
	logic halted;
	logic illegal;

	logic [31:0] progAddr [$];
	logic [31:0] progWord [$];
	logic [4:0] expRd [$];
	logic [31:0] expData [$];

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int cyclesUsed = 0;
	int cycleBudget = 1000;

	rvCore #(.memWords(256)) i_dut (
		.clk (clk),
		.rstN (rstN),
		.run (run),
		.loadEn (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.retireValid (retireValid),
		.retireRd (retireRd),
		.retireData (retireData),
		.halted (halted),
		.illegal (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// budget is reloaded by every program
	initial begin
		while (cyclesUsed <= cycleBudget) begin
			@(posedge clk);
			cyclesUsed = cyclesUsed + 1;
		end
		$display("Watchdog: program %0d did not halt within %0d cycles", testCount, cycleBudget);
		$display("TEST FAIL");
		$finish;
	end

	task automatic checkRetire();
		logic [4:0] headRd;
		logic [31:0] headData;
		assert (expRd.size() > 0) else begin
			$display("Unexpected write of 0x%08h to x%0d at %0t ns, no write was expected",
				retireData, retireRd, $time);
			errorCount++;
		end
		if (expRd.size() > 0) begin
			headRd = expRd.pop_front();
			headData = expData.pop_front();
			checkCount++;
			assert (retireRd === headRd) else begin
				$display("Mismatch at %0t ns: retireRd expected %0d, got %0d",
					$time, headRd, retireRd);
				errorCount++;
			end
			assert (retireData === headData) else begin
				$display("Mismatch at %0t ns: retireData expected 0x%08h, got 0x%08h",
					$time, headData, retireData);
				errorCount++;
			end
		end
	endtask

	// retire monitor
	initial begin
		forever begin
			@(negedge clk);
			if (rstN && retireValid) begin
				checkRetire();
			end
		end
	end

	task automatic runProgram(input logic expIllegal);
		int errorsBefore;
		int checksBefore;
		int words;
		errorsBefore = errorCount;
		checksBefore = checkCount;
		words = progWord.size();
		testCount = testCount + 1;
		cyclesUsed = 0;
		cycleBudget = 200 * words + 20;
		@(posedge clk);
		rstN <= 1'b0;
		run <= 1'b0;
		loadEn <= 1'b0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		// loader writes one word per cycle while run is low
		for (int i = 0; i < words; i++) begin
			@(posedge clk);
			loadEn <= 1'b1;
			loadAddr <= progAddr[i];
			loadData <= progWord[i];
		end
		@(posedge clk);
		loadEn <= 1'b0;
		run <= 1'b1;
		while (halted !== 1'b1) begin
			@(negedge clk);
		end
		// quiet window, nothing may retire after the halt
		repeat (8) @(negedge clk);
		assert (halted === 1'b1) else begin
			$display("Program %0d: halted dropped again before the next reset", testCount);
			errorCount++;
		end
		assert (illegal === expIllegal) else begin
			$display("Mismatch at %0t ns: illegal expected %0b, got %0b",
				$time, expIllegal, illegal);
			errorCount++;
		end
		assert (expRd.size() == 0) else begin
			$display("Program %0d halted with %0d expected register writes missing",
				testCount, expRd.size());
			errorCount++;
		end
		$display("program %0d finished: %0d words, %0d writes checked, %0d errors",
			testCount, words, checkCount - checksBefore, errorCount - errorsBefore);
		progAddr.delete();
		progWord.delete();
		expRd.delete();
		expData.delete();
	endtask

	initial begin
		int fd;
		int code;
		logic [7:0] tag;
		logic [31:0] fieldA;
		logic [31:0] fieldB;
		logic [1023:0] skipLine;
		rstN = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		fd = $fopen("sim/rvStimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open sim/rvStimulus.txt");
			$display("TEST FAIL");
			$finish;
		end else begin
			code = $fscanf(fd, " %c", tag);
			while (code == 1) begin
				case (tag)
					"P": begin
						code = $fscanf(fd, "%h %h", fieldA, fieldB);
						progAddr.push_back(fieldA);
						progWord.push_back(fieldB);
					end
					"E": begin
						code = $fscanf(fd, "%h %h", fieldA, fieldB);
						expRd.push_back(fieldA[4:0]);
						expData.push_back(fieldB);
					end
					"H": begin
						code = $fscanf(fd, "%h", fieldA);
						runProgram(fieldA[0]);
					end
					"#": code = $fgets(skipLine, fd);
					default: begin
						$display("Stimulus file has a line with unknown tag %c", tag);
						errorCount++;
						code = $fgets(skipLine, fd);
					end
				endcase
				code = $fscanf(fd, " %c", tag);
			end
			$fclose(fd);
			$display("%0d programs run, %0d writes checked, %0d errors",
				testCount, checkCount, errorCount);
			if (errorCount == 0 && testCount > 0) begin
				$display("TEST PASS");
			end else begin
				$display("TEST FAIL");
			end
			$finish;
		end
	end

endmodule

//--- logic/rvCore.sv
/*
  Three-stage RV32I subset core: fetch, execute, memory/writeback.
  loadAddr is a byte address and the loader only writes while run is
  low. retireValid flags every register write, x0 included.
  halted and illegal rise the cycle after EBREAK or a bad opcode
  reaches writeback and hold until reset.
*/
`timescale 1ns/1ns

module rvCore #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic loadEn,
	input logic [31:0] loadAddr,
	input logic [31:0] loadData,
	output logic retireValid,
	output logic [4:0] retireRd,
	output logic [31:0] retireData,
	output logic halted,
	output logic illegal
);
	import rvPkg::*;

	memBus loadBus ();
	memBus dataBus ();
	memBus fetchBus ();

	instWord_u inst;
	logic [31:0] instPc;
	logic instValid;
	logic stall;
	logic haltReq;
	logic exFire;
	logic redirect;
	logic [31:0] redirectPc;

	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [31:0] imm;
	aluOp_e aluOp;
	logic useImm;
	logic regWen;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic branchNe;
	logic isJal;
	logic isEbreak;
	logic isIllegal;

	logic [31:0] rData1;
	logic [31:0] rData2;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluResult;

	// memory/writeback stage
	logic wbValid;
	logic wbRegWen;
	logic wbIsLoad;
	logic wbIsStore;
	logic wbIsJal;
	logic wbHalt;
	logic wbIllegal;
	logic wbLoadGnt;
	logic [4:0] wbRd;
	logic [31:0] wbAlu;
	logic [31:0] wbStoreData;
	logic [31:0] wbLinkPc;
	logic [31:0] wbData;

	assign loadBus.req = loadEn & ~run;
	assign loadBus.we = 1'b1;
	assign loadBus.addr = loadAddr[31:2];
	assign loadBus.wdata = loadData;

	memArbiter #(.memWords(memWords)) uArbiter (
		.clk (clk),
		.rstN (rstN),
		.loadBus (loadBus),
		.dataBus (dataBus),
		.fetchBus (fetchBus)
	);

	fetchUnit uFetch (
		.clk (clk),
		.rstN (rstN),
		.run (run),
		.stall (stall),
		.halt (haltReq),
		.redirect (redirect),
		.redirectPc (redirectPc),
		.fetchBus (fetchBus),
		.inst (inst),
		.instPc (instPc),
		.instValid (instValid)
	);

	instDecoder uDecoder (
		.inst (inst),
		.rs1 (rs1),
		.rs2 (rs2),
		.rd (rd),
		.imm (imm),
		.aluOp (aluOp),
		.useImm (useImm),
		.regWen (regWen),
		.isLoad (isLoad),
		.isStore (isStore),
		.isBranch (isBranch),
		.branchNe (branchNe),
		.isJal (isJal),
		.isEbreak (isEbreak),
		.isIllegal (isIllegal)
	);

	regFile uRegs (
		.clk (clk),
		.rstN (rstN),
		.wen (retireValid),
		.wAddr (wbRd),
		.wData (wbData),
		.rAddr1 (rs1),
		.rAddr2 (rs2),
		.rData1 (rData1),
		.rData2 (rData2)
	);

	// execute waits on an unfinished memory access or a pending halt
	assign stall = wbValid & ((wbIsStore & ~dataBus.gnt) | (wbIsLoad & ~dataBus.rdValid));
	assign haltReq = halted | (wbValid & wbHalt);
	assign exFire = instValid & ~stall & ~haltReq;

	// forward the value being written back this cycle
	assign opA = (retireValid && wbRd == rs1 && rs1 != 5'd0) ? wbData : rData1;
	assign opB = (retireValid && wbRd == rs2 && rs2 != 5'd0) ? wbData : rData2;

	intAlu uAlu (
		.op (aluOp),
		.a (opA),
		.b (useImm ? imm : opB),
		.result (aluResult)
	);

	assign redirect = exFire & (isJal | (isBranch & (aluResult[0] ^ branchNe)));
	assign redirectPc = instPc + imm;

	always_ff @(posedge clk) begin
		if (exFire) begin
			wbRd <= rd;
			wbAlu <= aluResult;
			wbStoreData <= opB;
			wbLinkPc <= instPc + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			wbRegWen <= 1'b0;
			wbIsLoad <= 1'b0;
			wbIsStore <= 1'b0;
			wbIsJal <= 1'b0;
			wbHalt <= 1'b0;
			wbIllegal <= 1'b0;
			wbLoadGnt <= 1'b0;
		end else if (exFire) begin
			wbValid <= 1'b1;
			wbRegWen <= regWen;
			wbIsLoad <= isLoad;
			wbIsStore <= isStore;
			wbIsJal <= isJal;
			wbHalt <= isEbreak | isIllegal;
			wbIllegal <= isIllegal;
			wbLoadGnt <= 1'b0;
		end else if (!stall) begin
			wbValid <= 1'b0;
			wbLoadGnt <= 1'b0;
		end else if (dataBus.gnt) begin
			// load granted, now only waiting for rdValid
			wbLoadGnt <= 1'b1;
		end
	end

	assign dataBus.req = wbValid & (wbIsStore | (wbIsLoad & ~wbLoadGnt));
	assign dataBus.we = wbIsStore;
	assign dataBus.addr = wbAlu[31:2];
	assign dataBus.wdata = wbStoreData;

	assign wbData = wbIsLoad ? dataBus.rdata : (wbIsJal ? wbLinkPc : wbAlu);

	assign retireValid = wbValid & wbRegWen & (~wbIsLoad | dataBus.rdValid);
	assign retireRd = wbRd;
	assign retireData = wbData;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
			illegal <= 1'b0;
		end else if (wbValid && wbHalt) begin
			halted <= 1'b1;
			illegal <= wbIllegal;
		end
	end

endmodule

//--- logic/memArbiter.sv
/*
  Fixed-priority arbiter in front of a single-port synchronous RAM.
  Priority is loader, then data, then fetch. Grants are combinational
  on req. Word addresses wrap modulo memWords, which should be a
  power of two. RAM contents are undefined until loaded.
*/
`timescale 1ns/1ns

module memArbiter #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic rstN,
	memBus.arbiter loadBus,
	memBus.arbiter dataBus,
	memBus.arbiter fetchBus
);

	localparam int addrWidth = $clog2(memWords);

	logic [31:0] ram [memWords];
	logic [31:0] rdWord;
	logic [addrWidth-1:0] selAddr;
	logic selWe;
	logic [31:0] selData;
	logic anyReq;

	assign loadBus.gnt = loadBus.req;
	assign dataBus.gnt = dataBus.req & ~loadBus.req;
	assign fetchBus.gnt = fetchBus.req & ~loadBus.req & ~dataBus.req;
	assign anyReq = loadBus.req | dataBus.req | fetchBus.req;

	// route the granted requester to the RAM port
	always_comb begin
		if (loadBus.req) begin
			selAddr = loadBus.addr[addrWidth-1:0];
			selWe = loadBus.we;
			selData = loadBus.wdata;
		end else if (dataBus.req) begin
			selAddr = dataBus.addr[addrWidth-1:0];
			selWe = dataBus.we;
			selData = dataBus.wdata;
		end else begin
			selAddr = fetchBus.addr[addrWidth-1:0];
			selWe = fetchBus.we;
			selData = fetchBus.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (anyReq) begin
			if (selWe) begin
				ram[selAddr] <= selData;
			end else begin
				rdWord <= ram[selAddr];
			end
		end
	end

	assign loadBus.rdata = rdWord;
	assign dataBus.rdata = rdWord;
	assign fetchBus.rdata = rdWord;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			loadBus.rdValid <= 1'b0;
			dataBus.rdValid <= 1'b0;
			fetchBus.rdValid <= 1'b0;
		end else begin
			loadBus.rdValid <= loadBus.gnt & ~loadBus.we;
			dataBus.rdValid <= dataBus.gnt & ~dataBus.we;
			fetchBus.rdValid <= fetchBus.gnt & ~fetchBus.we;
		end
	end

endmodule

//--- logic/fetchUnit.sv
/*
  Fetch stage with one outstanding request at a time.
  A new fetch is issued only while the instruction register is empty
  or being consumed, so a returning word never overwrites a live one.
  A fetch issued in the cycle of a redirect returns as a NOP bubble.
*/
`timescale 1ns/1ns

module fetchUnit (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic stall,
	input logic halt,
	input logic redirect,
	input logic [31:0] redirectPc,
	memBus.requester fetchBus,
	output rvPkg::instWord_u inst,
	output logic [31:0] instPc,
	output logic instValid
);
	import rvPkg::*;

	logic [31:0] pc;
	logic [29:0] holdAddr;
	logic holdReq;
	logic inFlight;
	logic dropNext;
	logic issue;
	logic take;

	assign take = instValid & ~stall & ~halt;
	assign issue = run & ~stall & ~halt & ~holdReq & ~inFlight;

	assign fetchBus.req = issue | holdReq;
	// a waiting request keeps the address it was issued with
	assign fetchBus.addr = holdReq ? holdAddr : pc[31:2];
	assign fetchBus.we = 1'b0;
	assign fetchBus.wdata = '0;

	always_ff @(posedge clk) begin
		if (issue) begin
			holdAddr <= pc[31:2];
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= pcReset;
			holdReq <= 1'b0;
			inFlight <= 1'b0;
			dropNext <= 1'b0;
			inst <= nopWord;
			instPc <= pcReset;
			instValid <= 1'b0;
		end else begin
			holdReq <= fetchBus.req & ~fetchBus.gnt;
			inFlight <= fetchBus.gnt;
			if (fetchBus.rdValid) begin
				if (dropNext) begin
					// wrong-path word becomes a bubble
					inst <= nopWord;
					instValid <= 1'b0;
					dropNext <= 1'b0;
				end else begin
					inst <= fetchBus.rdata;
					instPc <= pc;
					instValid <= 1'b1;
					pc <= pc + 32'd4;
				end
			end else if (take) begin
				inst <= nopWord;
				instValid <= 1'b0;
			end
			if (redirect) begin
				pc <= redirectPc;
				dropNext <= fetchBus.req;
			end
		end
	end

endmodule

//--- logic/instDecoder.sv
/*
  Decoder for the supported subset: ADD SUB AND OR XOR SLT ADDI LW SW
  BEQ BNE JAL EBREAK. Every other encoding raises isIllegal and
  writes no register.
*/
`timescale 1ns/1ns

module instDecoder (
	input rvPkg::instWord_u inst,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [31:0] imm,
	output rvPkg::aluOp_e aluOp,
	output logic useImm,
	output logic regWen,
	output logic isLoad,
	output logic isStore,
	output logic isBranch,
	output logic branchNe,
	output logic isJal,
	output logic isEbreak,
	output logic isIllegal
);
	import rvPkg::*;

	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immJ;

	assign rs1 = inst.r.rs1;
	assign rs2 = inst.r.rs2;
	assign rd = inst.r.rd;

	assign immI = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign immS = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
	assign immB = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10to5,
		inst.b.imm4to1, 1'b0};
	// jal offset pieces sit in the funct7, rs2, rs1 and funct3 fields
	assign immJ = {{12{inst.r.funct7[6]}}, inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
		inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};

	always_comb begin
		imm = immI;
		aluOp = aluAdd;
		useImm = 1'b0;
		regWen = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isBranch = 1'b0;
		branchNe = 1'b0;
		isJal = 1'b0;
		isEbreak = 1'b0;
		isIllegal = 1'b0;
		case (inst.r.opcode)
			opcOp: begin
				regWen = 1'b1;
				case ({inst.r.funct7, inst.r.funct3})
					{7'h00, 3'b000}: aluOp = aluAdd;
					{7'h20, 3'b000}: aluOp = aluSub;
					{7'h00, 3'b111}: aluOp = aluAnd;
					{7'h00, 3'b110}: aluOp = aluOr;
					{7'h00, 3'b100}: aluOp = aluXor;
					{7'h00, 3'b010}: aluOp = aluSlt;
					default: begin
						regWen = 1'b0;
						isIllegal = 1'b1;
					end
				endcase
			end
			opcOpImm, opcLoad: begin
				// addi and lw only, both add rs1 and the I immediate
				useImm = 1'b1;
				regWen = (inst.i.funct3 == ((inst.i.opcode == opcLoad) ? 3'b010 : 3'b000));
				isLoad = regWen & (inst.i.opcode == opcLoad);
				isIllegal = ~regWen;
			end
			opcStore: begin
				imm = immS;
				useImm = 1'b1;
				isStore = (inst.s.funct3 == 3'b010);
				isIllegal = ~isStore;
			end
			opcBranch: begin
				imm = immB;
				aluOp = aluEq;
				isBranch = (inst.b.funct3[2:1] == 2'b00);
				branchNe = inst.b.funct3[0];
				isIllegal = ~isBranch;
			end
			opcJal: begin
				imm = immJ;
				regWen = 1'b1;
				isJal = 1'b1;
			end
			opcSystem: begin
				isEbreak = (inst.i.imm == 12'h001) && (inst.i.rs1 == 5'd0) &&
					(inst.i.funct3 == 3'b000) && (inst.i.rd == 5'd0);
				isIllegal = ~isEbreak;
			end
			default: isIllegal = 1'b1;
		endcase
	end

endmodule

//--- logic/regFile.sv
/*
  32 x 32 integer registers, two combinational reads, one write.
  Writes to x0 are dropped so it always reads zero.
  There is no internal bypass, the core forwards the write itself.
*/
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic rstN,
	input logic wen,
	input logic [4:0] wAddr,
	input logic [31:0] wData,
	input logic [4:0] rAddr1,
	input logic [4:0] rAddr2,
	output logic [31:0] rData1,
	output logic [31:0] rData2
);

	logic [31:0] regs [32];

	assign rData1 = regs[rAddr1];
	assign rData2 = regs[rAddr2];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wAddr != 5'd0) begin
			regs[wAddr] <= wData;
		end
	end

endmodule

//--- logic/intAlu.sv
/*
  Integer ALU. slt and eq return 0 or 1 in bit 0, and eq doubles as
  the branch compare.
*/
`timescale 1ns/1ns

module intAlu (
	input rvPkg::aluOp_e op,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] result
);
	import rvPkg::*;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			// signed compare
			aluSlt: result = {31'd0, $signed(a) < $signed(b)};
			aluEq: result = {31'd0, a == b};
			default: result = '0;
		endcase
	end

endmodule

//--- logic/memBus.sv
/*
  One requester's port into the unified memory.
  addr is a word address. req is held until gnt and addr, we and
  wdata stay stable meanwhile. Read data comes back with rdValid one
  cycle after the grant. Writes return nothing.
*/
`timescale 1ns/1ns

interface memBus;
	logic req;
	logic we;
	logic [29:0] addr;
	logic [31:0] wdata;
	logic gnt;
	logic [31:0] rdata;
	logic rdValid;

	modport requester (output req, we, addr, wdata, input gnt, rdata, rdValid);
	modport arbiter (input req, we, addr, wdata, output gnt, rdata, rdValid);
endinterface

//--- logic/rvPkg.sv
/*
  Shared definitions for the three-stage RV32I subset core.
  Only the base formats the core decodes are overlaid on the
  instruction word. The J-type immediate is rebuilt from the R view.
*/
package rvPkg;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluEq
	} aluOp_e;

	// major opcodes, bits [6:0]
	localparam logic [6:0] opcOp = 7'b0110011;
	localparam logic [6:0] opcOpImm = 7'b0010011;
	localparam logic [6:0] opcLoad = 7'b0000011;
	localparam logic [6:0] opcStore = 7'b0100011;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcJal = 7'b1101111;
	localparam logic [6:0] opcSystem = 7'b1110011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rType_s;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iType_s;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sType_s;

	// branch offset bits are scattered, bit 0 is implied zero
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bType_s;

	typedef union packed {
		rType_s r;
		iType_s i;
		sType_s s;
		bType_s b;
	} instWord_u;

	localparam logic [31:0] pcReset = 32'h0000_0000;
	// addi x0, x0, 0
	localparam logic [31:0] nopWord = 32'h0000_0013;

endpackage
